// ==== ic_settings.svh ====
// instruction cache settings: address split, line geometry, fetch width and set count
`ifndef IC_SETTINGS_SVH
`define IC_SETTINGS_SVH

////////////////////////////////////////////////////////////
// fetch address
////////////////////////////////////////////////////////////

// pc and instruction widths
`define IC_PC_BITS        32
`define IC_INST_BITS      32
// byte offset inside one instruction
`define IC_INST_BYTE_LOG  2

////////////////////////////////////////////////////////////
// line and set geometry
////////////////////////////////////////////////////////////

// slot select inside a line, 8 slots of 32 bits
`define IC_OFFSET_BITS    3
`define IC_INSTS_IN_LINE  8
`define IC_LINE_BITS      256
// set index, 32 sets per way
`define IC_INDEX_BITS     5
`define IC_NUM_SETS       32
// tag is whatever is left above index and offset
`define IC_TAG_BITS       22

// slots handed to the fetch stage per lookup
`define IC_FETCH_WIDTH    4

`endif

// ==== ic_pkg.sv ====
// instruction cache package: width typedefs, bus structs and miss state enum
`include "ic_settings.svh"

package ic_pkg;

  ////////////////////////////////////////////////////////////
  // plain width types
  ////////////////////////////////////////////////////////////

  typedef logic [`IC_PC_BITS-1:0]      pc_t;
  typedef logic [`IC_TAG_BITS-1:0]     ic_tag_t;
  typedef logic [`IC_INDEX_BITS-1:0]   ic_index_t;
  typedef logic [`IC_OFFSET_BITS-1:0]  ic_offset_t;
  typedef logic [`IC_INST_BITS-1:0]    inst_t;
  // slot k sits at bits 32k upward
  typedef logic [`IC_LINE_BITS-1:0]    ic_line_t;
  typedef logic [0:0]                  ic_way_t;
  // bit 0 belongs to slot 0
  typedef logic [`IC_FETCH_WIDTH-1:0]  fetch_valid_t;

  ////////////////////////////////////////////////////////////
  // grouped signals
  ////////////////////////////////////////////////////////////

  // instructions to fetch, slot 0 in the low word
  typedef struct packed {
    inst_t [`IC_FETCH_WIDTH-1:0] inst;
    fetch_valid_t                valid;
  } fetch_bundle_t;

  // line request, block address is tag then index
  typedef struct packed {
    logic [`IC_TAG_BITS+`IC_INDEX_BITS-1:0] blk_addr;
    ic_way_t                                way;
  } mem_req_t;

  // line returned by memory
  typedef struct packed {
    ic_tag_t   tag;
    ic_index_t index;
    ic_line_t  line;
  } mem_resp_t;

  // single line invalidation
  typedef struct packed {
    ic_index_t index;
    ic_way_t   way;
  } inv_req_t;

  // array write for a completed miss
  typedef struct packed {
    ic_index_t index;
    ic_tag_t   tag;
    ic_way_t   way;
    ic_line_t  line;
  } fill_t;

  // single miss register
  typedef enum logic {
    MISS_IDLE,
    MISS_WAIT
  } miss_state_t;

endpackage

// ==== ic_tag_store.sv ====
// instruction cache tag store: valid and tag arrays, two-way lookup, flush/invalidate/fill
`timescale 1ns/100ps
`include "ic_settings.svh"

module ic_tag_store
  import ic_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      flush_i,
  input  logic      inv_valid_i,
  input  inv_req_t  inv_i,
  input  logic      fill_valid_i,
  input  fill_t     fill_i,
  input  ic_index_t lookup_index_i,
  input  ic_tag_t   lookup_tag_i,
  input  logic      fetch_req_i,
  output logic [1:0] hit_way_o
);

  ////////////////////////////////////////////////////////////
  // arrays
  ////////////////////////////////////////////////////////////

  // one valid bit per set and way
  logic [`IC_NUM_SETS-1:0] valid_q [2];
  // tags per set and way
  ic_tag_t                 tag_q   [2][`IC_NUM_SETS];

  // tag written with the fill line
  always_ff @(posedge clk)
  begin
    if (fill_valid_i)
    begin
      tag_q[fill_i.way][fill_i.index] <= fill_i.tag;
    end
  end

  // valid bits
  // flush beats invalidation, invalidation beats fill on the same entry
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
    end
    else if (flush_i)
    begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
    end
    else
    begin
      if (fill_valid_i)
      begin
        valid_q[fill_i.way][fill_i.index] <= 1'b1;
      end
      // later write wins on a collision
      if (inv_valid_i)
      begin
        valid_q[inv_i.way][inv_i.index] <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////

  // both ways compared in the same cycle, only while fetch asks
  always_comb
  begin
    for (int w = 0; w < 2; w++)
    begin
      hit_way_o[w] = fetch_req_i
                   & valid_q[w][lookup_index_i]
                   & (tag_q[w][lookup_index_i] == lookup_tag_i);
    end
  end

  // a line is only filled after missing in both ways
  // so one tag never lives twice in a set
  a_one_way_hit : assert property (
    @(posedge clk) disable iff (reset)
    !(hit_way_o[0] && hit_way_o[1])
  );

endmodule

// ==== ic_data_store.sv ====
// instruction cache data store: line arrays, fill writes and fetch slot extraction
`timescale 1ns/100ps
`include "ic_settings.svh"

module ic_data_store
  import ic_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          fill_valid_i,
  input  fill_t         fill_i,
  input  ic_index_t     lookup_index_i,
  input  ic_offset_t    lookup_offset_i,
  input  logic [1:0]    hit_way_i,
  output fetch_bundle_t fetch_o
);

  ////////////////////////////////////////////////////////////
  // line arrays
  ////////////////////////////////////////////////////////////

  ic_line_t data_q [2][`IC_NUM_SETS];

  // fill line goes into the way held by the miss register
  // no writes while reset is held
  always_ff @(posedge clk)
  begin
    if (fill_valid_i && !reset)
    begin
      data_q[fill_i.way][fill_i.index] <= fill_i.line;
    end
  end

  ////////////////////////////////////////////////////////////
  // slot extraction
  ////////////////////////////////////////////////////////////

  logic                       any_hit;
  ic_line_t                   hit_line;
  // upper half reads as zero past the line end
  logic [2*`IC_LINE_BITS-1:0] hit_line_ext;

  assign any_hit = |hit_way_i;

  // pick the way that hit, way 0 otherwise
  assign hit_line     = hit_way_i[1] ? data_q[1][lookup_index_i]
                                     : data_q[0][lookup_index_i];
  assign hit_line_ext = {{`IC_LINE_BITS{1'b0}}, hit_line};

  always_comb
  begin
    for (int i = 0; i < `IC_FETCH_WIDTH; i++)
    begin
      // slot i starts at offset plus i
      if (any_hit)
      begin
        fetch_o.inst[i] =
          hit_line_ext[(int'(lookup_offset_i) + i) * `IC_INST_BITS +: `IC_INST_BITS];
      end
      else
      begin
        fetch_o.inst[i] = '0;
      end
      // valid only while still inside the line
      fetch_o.valid[i] = any_hit && ((int'(lookup_offset_i) + i) < `IC_INSTS_IN_LINE);
    end
  end

endmodule

// ==== ic_victim_select.sv ====
// instruction cache victim select: per-set round-robin way bits
`timescale 1ns/100ps
`include "ic_settings.svh"

module ic_victim_select
  import ic_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      fill_valid_i,
  input  ic_index_t fill_index_i,
  input  ic_index_t lookup_index_i,
  output ic_way_t   victim_way_o
);

  // one round-robin bit per set, 0 selects way 0
  logic [`IC_NUM_SETS-1:0] rr_q;

  // advance only when a fill actually lands in the set
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rr_q <= '0;
    end
    else if (fill_valid_i)
    begin
      rr_q[fill_index_i] <= ~rr_q[fill_index_i];
    end
  end

  // victim for the set being looked up
  assign victim_way_o = rr_q[lookup_index_i];

endmodule

// ==== ic_miss_fsm.sv ====
// instruction cache miss handling with miss pulse, single miss register, request and fill
`timescale 1ns/100ps
`include "ic_settings.svh"

module ic_miss_fsm
  import ic_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      fetch_req_i,
  input  logic      hit_i,
  input  ic_tag_t   pc_tag_i,
  input  ic_index_t pc_index_i,
  input  ic_way_t   victim_way_i,
  input  logic      mem_resp_valid_i,
  input  mem_resp_t mem_resp_i,
  output logic      mem_req_valid_o,
  output mem_req_t  mem_req_o,
  output logic      fill_valid_o,
  output fill_t     fill_o
);

  ////////////////////////////////////////////////////////////
  // lookup history
  ////////////////////////////////////////////////////////////

  // address and victim of the previous lookup
  ic_tag_t   pc_tag_q;
  ic_index_t pc_index_q;
  ic_way_t   victim_q;

  always_ff @(posedge clk)
  begin
    pc_tag_q   <= pc_tag_i;
    pc_index_q <= pc_index_i;
    victim_q   <= victim_way_i;
  end

  logic miss;
  logic miss_d1;
  logic miss_d2;
  logic miss_pulse;

  assign miss = fetch_req_i & ~hit_i;

  // a fill clears the history so a still pending miss pulses again
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      miss_d1 <= miss & ~fill_valid_o;
      miss_d2 <= miss_d1 & ~fill_valid_o;
    end
  end

  // first cycle of a miss run seen one cycle late
  assign miss_pulse = miss_d1 & ~miss_d2;

  ////////////////////////////////////////////////////////////
  // miss register
  ////////////////////////////////////////////////////////////

  miss_state_t state_q;
  miss_state_t state_d;
  ic_tag_t     mshr_tag_q;
  ic_index_t   mshr_index_q;
  ic_way_t     mshr_way_q;
  logic        resp_match;

  // issue only when the register is free or frees up this cycle
  // otherwise fetch just replays
  assign mem_req_valid_o    = miss_pulse & ((state_q == MISS_IDLE) | fill_valid_o);
  assign mem_req_o.blk_addr = {pc_tag_q, pc_index_q};
  assign mem_req_o.way      = victim_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      MISS_IDLE:
      begin
        if (mem_req_valid_o)
        begin
          state_d = MISS_WAIT;
        end
      end
      MISS_WAIT:
      begin
        // back to idle on fill unless a new miss reloads at once
        if (fill_valid_o && !mem_req_valid_o)
        begin
          state_d = MISS_IDLE;
        end
      end
      default:
      begin
        state_d = MISS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q <= MISS_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // address and way captured with each issued request
  always_ff @(posedge clk)
  begin
    if (mem_req_valid_o)
    begin
      mshr_tag_q   <= pc_tag_q;
      mshr_index_q <= pc_index_q;
      mshr_way_q   <= victim_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // fill
  ////////////////////////////////////////////////////////////

  // responses for anything but the held block are dropped
  assign resp_match = mem_resp_valid_i
                    & (state_q == MISS_WAIT)
                    & (mem_resp_i.tag == mshr_tag_q)
                    & (mem_resp_i.index == mshr_index_q);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fill_valid_o <= 1'b0;
    end
    else
    begin
      fill_valid_o <= resp_match;
    end
  end

  always_ff @(posedge clk)
  begin
    if (resp_match)
    begin
      fill_o.index <= mshr_index_q;
      fill_o.tag   <= mshr_tag_q;
      fill_o.way   <= mshr_way_q;
      fill_o.line  <= mem_resp_i.line;
    end
  end

  // memory answers each held miss once so every fill finds the register busy
  a_fill_while_busy : assert property (
    @(posedge clk) disable iff (reset)
    fill_valid_o |-> (state_q == MISS_WAIT)
  );

endmodule

// ==== icache_top.sv ====
// instruction cache top: pc split, store/victim/miss wiring and flush done
`timescale 1ns/100ps
`include "ic_settings.svh"

module icache_top
  import ic_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  // fetch stage
  input  logic          fetch_req_i,
  input  pc_t           pc_i,
  output fetch_bundle_t fetch_o,
  // memory side
  output logic          mem_req_valid_o,
  output mem_req_t      mem_req_o,
  output logic          ic_miss_o,
  input  logic          mem_resp_valid_i,
  input  mem_resp_t     mem_resp_i,
  // maintenance
  input  logic          inv_valid_i,
  input  inv_req_t      inv_i,
  input  logic          flush_i,
  output logic          flush_done_o
);

  ////////////////////////////////////////////////////////////
  // pc split
  ////////////////////////////////////////////////////////////

  // | tag 31:10 | index 9:5 | offset 4:2 | byte 1:0 |
  localparam int OFF_LO = `IC_INST_BYTE_LOG;
  localparam int IDX_LO = OFF_LO + `IC_OFFSET_BITS;
  localparam int TAG_LO = IDX_LO + `IC_INDEX_BITS;

  ic_offset_t pc_offset;
  ic_index_t  pc_index;
  ic_tag_t    pc_tag;

  assign pc_offset = pc_i[IDX_LO-1:OFF_LO];
  assign pc_index  = pc_i[TAG_LO-1:IDX_LO];
  assign pc_tag    = pc_i[`IC_PC_BITS-1:TAG_LO];

  logic [1:0] hit_way;
  logic       fill_valid;
  fill_t      fill;
  ic_way_t    victim_way;

  ic_tag_store u_tag_store (
    .clk            (clk),
    .reset          (reset),
    .flush_i        (flush_i),
    .inv_valid_i    (inv_valid_i),
    .inv_i          (inv_i),
    .fill_valid_i   (fill_valid),
    .fill_i         (fill),
    .lookup_index_i (pc_index),
    .lookup_tag_i   (pc_tag),
    .fetch_req_i    (fetch_req_i),
    .hit_way_o      (hit_way)
  );

  ic_data_store u_data_store (
    .clk             (clk),
    .reset           (reset),
    .fill_valid_i    (fill_valid),
    .fill_i          (fill),
    .lookup_index_i  (pc_index),
    .lookup_offset_i (pc_offset),
    .hit_way_i       (hit_way),
    .fetch_o         (fetch_o)
  );

  ic_victim_select u_victim_select (
    .clk            (clk),
    .reset          (reset),
    .fill_valid_i   (fill_valid),
    .fill_index_i   (fill.index),
    .lookup_index_i (pc_index),
    .victim_way_o   (victim_way)
  );

  // miss handler sees the combined hit of both ways
  ic_miss_fsm u_miss_fsm (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req_i),
    .hit_i            (|hit_way),
    .pc_tag_i         (pc_tag),
    .pc_index_i       (pc_index),
    .victim_way_i     (victim_way),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_i       (mem_resp_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_o        (mem_req_o),
    .fill_valid_o     (fill_valid),
    .fill_o           (fill)
  );

  assign ic_miss_o = mem_req_valid_o;

  // valid bits are clear one edge after flush
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      flush_done_o <= 1'b0;
    end
    else
    begin
      flush_done_o <= flush_i;
    end
  end

endmodule

// ==== tb_icache.sv ====
// testbench for the instruction cache: clock, reset, memory model, reference model, checks
`timescale 1ns/100ps
`include "ic_settings.svh"

module tb_icache
  import ic_pkg::*;
();

  ////////////////////////////////////////////////////////////
  // run limits and addresses
  ////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  // cycle budget per phase, one miss takes up to about 15 cycles
  localparam int LEN_RESET = 10;
  localparam int LEN_COLD  = 30;
  localparam int LEN_OFFS  = 40;
  localparam int LEN_EVICT = 90;
  localparam int LEN_INV   = 50;
  localparam int LEN_FLUSH = 70;
  localparam int LEN_BAD   = 40;
  localparam int CYCLE_LIMIT =
    2 * (LEN_RESET + LEN_COLD + LEN_OFFS + LEN_EVICT + LEN_INV + LEN_FLUSH + LEN_BAD);

  localparam ic_tag_t   TAG_A  = 22'h01234;
  localparam ic_index_t IDX_A  = 5'd5;
  // three tags competing for one set
  localparam ic_tag_t   TAG_B1 = 22'h000a1;
  localparam ic_tag_t   TAG_B2 = 22'h000b2;
  localparam ic_tag_t   TAG_B3 = 22'h000c3;
  localparam ic_index_t IDX_B  = 5'd9;
  localparam ic_tag_t   TAG_C  = 22'h30f0f;
  localparam ic_index_t IDX_C  = 5'd20;

  typedef logic [`IC_TAG_BITS+`IC_INDEX_BITS-1:0] blk_addr_t;

  // dut ports
  logic          clk;
  logic          reset;
  logic          fetch_req;
  pc_t           pc;
  fetch_bundle_t fetch;
  logic          mem_req_valid;
  mem_req_t      mem_req;
  logic          ic_miss;
  logic          mem_resp_valid;
  mem_resp_t     mem_resp;
  logic          inv_valid;
  inv_req_t      inv;
  logic          flush;
  logic          flush_done;

  // bookkeeping
  int          errors         = 0;
  int          checks         = 0;
  int          n_tests        = 0;
  int          n_failed       = 0;
  int          test_err_start = 0;
  int          cycle_cnt      = 0;
  int          pulse_count    = 0;
  int          req_ns         = 0;
  int          good_resp_ns   = 0;
  mem_req_t    last_req       = '0;
  // next response goes out with a wrong tag first
  logic        bad_first      = 1'b0;
  logic [15:0] lfsr_q         = 16'd7304;

  // resident tags and round-robin bits as the cache should hold them
  ic_tag_t model_tag [2][`IC_NUM_SETS];
  logic    model_vld [2][`IC_NUM_SETS];
  ic_way_t model_rr  [`IC_NUM_SETS];

  icache_top uut (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req),
    .pc_i             (pc),
    .fetch_o          (fetch),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_o        (mem_req),
    .ic_miss_o        (ic_miss),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_resp_i       (mem_resp),
    .inv_valid_i      (inv_valid),
    .inv_i            (inv),
    .flush_i          (flush),
    .flush_done_o     (flush_done)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr x^16+x^14+x^13+x^11+1, one step per bit
  function automatic int unsigned lfsr_take(input int nbits);
    int unsigned v;
    logic        fb;
    v = 0;
    for (int b = 0; b < nbits; b++)
    begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = (v << 1) | {31'd0, fb};
    end
    return v;
  endfunction

  function automatic ic_tag_t tag_of(input pc_t addr);
    return addr[`IC_PC_BITS-1 -: `IC_TAG_BITS];
  endfunction

  function automatic ic_index_t index_of(input pc_t addr);
    return addr[`IC_INST_BYTE_LOG+`IC_OFFSET_BITS +: `IC_INDEX_BITS];
  endfunction

  function automatic ic_offset_t offset_of(input pc_t addr);
    return addr[`IC_INST_BYTE_LOG +: `IC_OFFSET_BITS];
  endfunction

  function automatic pc_t make_pc(input ic_tag_t tag, input ic_index_t idx, input ic_offset_t off);
    return {tag, idx, off, {`IC_INST_BYTE_LOG{1'b0}}};
  endfunction

  // slot k of a block holds block address times 8 plus k
  function automatic ic_line_t line_of(input blk_addr_t blk);
    ic_line_t l;
    for (int k = 0; k < `IC_INSTS_IN_LINE; k++)
    begin
      l[k*`IC_INST_BITS +: `IC_INST_BITS] = inst_t'(blk) * `IC_INSTS_IN_LINE + inst_t'(k);
    end
    return l;
  endfunction

  // bundle the cache should show for this pc, from the model
  function automatic fetch_bundle_t expect_bundle(input pc_t addr);
    ic_tag_t       tag;
    ic_index_t     idx;
    ic_offset_t    off;
    ic_line_t      line;
    logic          hit;
    fetch_bundle_t b;
    tag  = tag_of(addr);
    idx  = index_of(addr);
    off  = offset_of(addr);
    hit  = (model_vld[0][idx] && (model_tag[0][idx] == tag))
        || (model_vld[1][idx] && (model_tag[1][idx] == tag));
    line = line_of({tag, idx});
    b    = '0;
    for (int i = 0; i < `IC_FETCH_WIDTH; i++)
    begin
      // slots past the line end stay invalid and zero
      if (hit && ((int'(off) + i) < `IC_INSTS_IN_LINE))
      begin
        b.inst[i]  = line[(int'(off) + i) * `IC_INST_BITS +: `IC_INST_BITS];
        b.valid[i] = 1'b1;
      end
    end
    return b;
  endfunction

  function automatic void model_fill(input ic_tag_t tag, input ic_index_t idx, input ic_way_t way);
    model_tag[way][idx] = tag;
    model_vld[way][idx] = 1'b1;
    model_rr[idx]       = ~model_rr[idx];
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_bundle(input fetch_bundle_t got, input fetch_bundle_t exp,
                              input string what);
    checks++;
    if (got.valid !== exp.valid)
    begin
      errors++;
      $display("error at %0t: %s, slot valids %b, expected %b",
               $time, what, got.valid, exp.valid);
    end
    else if ((exp.valid != '0) && (got.inst !== exp.inst))
    begin
      errors++;
      $display("error at %0t: %s, slots %h, expected %h", $time, what, got.inst, exp.inst);
    end
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s, request block %h way %0d, expected block %h way %0d",
               $time, what, got.blk_addr, got.way, exp.blk_addr, exp.way);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("error at %0t: %s counted %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_delay(input int got_ns, input int exp_ns, input string what);
    checks++;
    if (got_ns != exp_ns)
    begin
      errors++;
      $display("error at %0t: %s took %0d ns, expected %0d ns", $time, what, got_ns, exp_ns);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory side
  ////////////////////////////////////////////////////////////

  // every pulse is counted, ic_miss_o follows the pulse
  always @(negedge clk)
  begin
    if (mem_req_valid)
    begin
      pulse_count++;
      last_req = mem_req;
      req_ns   = int'($time);
    end
    if (mem_req_valid || ic_miss)
    begin
      check_flag(ic_miss, mem_req_valid, "ic_miss_o against mem_req_valid_o");
    end
  end

  task automatic send_resp(input blk_addr_t blk);
    mem_resp_valid <= 1'b1;
    mem_resp.tag   <= blk[`IC_TAG_BITS+`IC_INDEX_BITS-1 -: `IC_TAG_BITS];
    mem_resp.index <= blk[`IC_INDEX_BITS-1:0];
    mem_resp.line  <= line_of(blk);
    @(posedge clk);
    mem_resp_valid <= 1'b0;
  endtask

  // answers each request after 1 to 6 cycles
  always
  begin : mem_responder
    blk_addr_t   blk;
    int unsigned delay;
    @(negedge clk);
    if (mem_req_valid)
    begin
      blk   = mem_req.blk_addr;
      delay = 1 + lfsr_take(3) % 6;
      repeat (delay) @(posedge clk);
      if (bad_first)
      begin
        bad_first = 1'b0;
        // same set, neighbouring tag
        send_resp(blk ^ {ic_tag_t'(1), ic_index_t'(0)});
        repeat (2) @(posedge clk);
      end
      good_resp_ns = int'($time);
      send_resp(blk);
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("run stopped after %0d cycles without finishing the tests", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // test steps
  ////////////////////////////////////////////////////////////

  // fetch one pc, and on a miss hold it until the line is filled
  task automatic fetch_line(input pc_t addr, input string what);
    fetch_bundle_t exp;
    mem_req_t      exp_req;
    ic_tag_t       tag;
    ic_index_t     idx;
    int            start_pulses;
    int            miss_ns;
    int            hit_ns;
    logic          hit_exp;
    tag              = tag_of(addr);
    idx              = index_of(addr);
    exp              = expect_bundle(addr);
    hit_exp          = (exp.valid != '0);
    // a miss asks for the block with the victim of its set
    exp_req.blk_addr = {tag, idx};
    exp_req.way      = model_rr[idx];
    start_pulses     = pulse_count;
    @(posedge clk);
    fetch_req <= 1'b1;
    pc        <= addr;
    @(negedge clk);
    check_bundle(fetch, exp, {what, ", first cycle"});
    if (!hit_exp)
    begin
      miss_ns = int'($time);
      // fetch replays until it hits, the watchdog bounds the wait
      while (fetch.valid == '0)
      begin
        @(negedge clk);
      end
      hit_ns = int'($time);
      check_req(last_req, exp_req, what);
      check_delay(req_ns - miss_ns, CLK_PERIOD, {what, ", request after first miss"});
      check_delay(hit_ns - good_resp_ns, 2 * CLK_PERIOD + CLK_PERIOD / 2,
                  {what, ", hit after response"});
      model_fill(tag, idx, exp_req.way);
      exp = expect_bundle(addr);
      check_bundle(fetch, exp, {what, ", after fill"});
    end
    // held fetch keeps hitting and asks no more
    repeat (2)
    begin
      @(negedge clk);
      check_bundle(fetch, exp, {what, ", held"});
    end
    @(posedge clk);
    fetch_req <= 1'b0;
    check_count(pulse_count - start_pulses, hit_exp ? 0 : 1, {what, ", request pulses"});
  endtask

  task automatic invalidate(input ic_index_t idx, input ic_way_t way);
    @(posedge clk);
    inv_valid <= 1'b1;
    inv.index <= idx;
    inv.way   <= way;
    @(posedge clk);
    inv_valid <= 1'b0;
    model_vld[way][idx] = 1'b0;
  endtask

  task automatic flush_all();
    @(posedge clk);
    flush <= 1'b1;
    @(negedge clk);
    check_flag(flush_done, 1'b0, "flush_done_o in the flush cycle");
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check_flag(flush_done, 1'b1, "flush_done_o one cycle after flush");
    @(negedge clk);
    check_flag(flush_done, 1'b0, "flush_done_o two cycles after flush");
    // round-robin bits survive a flush
    for (int s = 0; s < `IC_NUM_SETS; s++)
    begin
      model_vld[0][s] = 1'b0;
      model_vld[1][s] = 1'b0;
    end
  endtask

  task automatic begin_test();
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (errors != test_err_start)
    begin
      n_failed++;
      $display("test %0d, %s: failed with %0d errors", n_tests, name, errors - test_err_start);
    end
    else
    begin
      $display("test %0d, %s: ok", n_tests, name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin : main
    reset          = 1'b1;
    fetch_req      = 1'b0;
    pc             = '0;
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    inv_valid      = 1'b0;
    inv            = '0;
    flush          = 1'b0;
    for (int s = 0; s < `IC_NUM_SETS; s++)
    begin
      model_tag[0][s] = '0;
      model_tag[1][s] = '0;
      model_vld[0][s] = 1'b0;
      model_vld[1][s] = 1'b0;
      model_rr[s]     = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // cold cache, one request per miss
    begin_test();
    @(negedge clk);
    check_flag(mem_req_valid, 1'b0, "mem_req_valid_o after reset");
    check_flag(flush_done, 1'b0, "flush_done_o after reset");
    fetch_line(make_pc(TAG_A, IDX_A, 3'd2), "cold fetch");
    end_test("cold miss and fill");

    begin_test();
    for (int o = 0; o < `IC_INSTS_IN_LINE; o++)
    begin
      fetch_line(make_pc(TAG_A, IDX_A, ic_offset_t'(o)), $sformatf("offset %0d", o));
    end
    end_test("slot values and valids per offset");

    // two ways fill, third tag takes way 0 back
    begin_test();
    fetch_line(make_pc(TAG_B1, IDX_B, 3'd0), "first tag");
    fetch_line(make_pc(TAG_B2, IDX_B, 3'd0), "second tag");
    fetch_line(make_pc(TAG_B1, IDX_B, 3'd4), "first tag again");
    fetch_line(make_pc(TAG_B2, IDX_B, 3'd6), "second tag again");
    fetch_line(make_pc(TAG_B3, IDX_B, 3'd1), "third tag");
    fetch_line(make_pc(TAG_B2, IDX_B, 3'd0), "second tag after eviction");
    fetch_line(make_pc(TAG_B1, IDX_B, 3'd0), "evicted first tag");
    end_test("round-robin eviction");

    begin_test();
    invalidate(IDX_B, 1'b0);
    fetch_line(make_pc(TAG_B1, IDX_B, 3'd0), "other way of invalidated set");
    fetch_line(make_pc(TAG_A, IDX_A, 3'd0), "other set");
    fetch_line(make_pc(TAG_B3, IDX_B, 3'd0), "invalidated line");
    end_test("invalidation by index and way");

    begin_test();
    flush_all();
    fetch_line(make_pc(TAG_A, IDX_A, 3'd0), "flushed line a");
    fetch_line(make_pc(TAG_B1, IDX_B, 3'd0), "flushed line b1");
    fetch_line(make_pc(TAG_B3, IDX_B, 3'd0), "flushed line b3");
    end_test("flush");

    // wrong tag is dropped, the right one fills
    begin_test();
    bad_first = 1'b1;
    fetch_line(make_pc(TAG_C, IDX_C, 3'd5), "fetch behind wrong response");
    end_test("mismatching response");

    $display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, checks, errors);
    if (errors == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
ic_pkg.sv
ic_tag_store.sv
ic_data_store.sv
ic_victim_select.sv
ic_miss_fsm.sv
icache_top.sv
tb_icache.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_icache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_icache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
